/* Makefile */
SRCS := $(filter-out +%,$(shell cat fmul_unit.f)) src/fmul_defines.svh tests/tb_fmul_model.svh

obj_dir/Vtb_fmul_unit: fmul_unit.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_fmul_unit -f fmul_unit.f

run: obj_dir/Vtb_fmul_unit
	@out=$$(./obj_dir/Vtb_fmul_unit); echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

.PHONY: run clean

/* fmul_unit.f */
+incdir+src
+incdir+tests
src/fmul_pkg.sv
src/fp_classifier.sv
src/mant_mul.sv
src/fp_rounding.sv
src/fmul_core.sv
src/fmul_csr.sv
src/fmul_unit.sv
tests/tb_fmul_unit.sv

/* src/fmul_core.sv */
`include "fmul_defines.svh"

module fmul_core (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       in_valid_i,
    input  logic [`FMUL_WIDTH-1:0]     a_i,
    input  logic [`FMUL_WIDTH-1:0]     b_i,
    input  fmul_pkg::roundmode_e       rm_i,
    output logic                       out_valid_o,
    output logic [`FMUL_WIDTH-1:0]     out_result_o,
    output logic [`FMUL_FLAG_BITS-1:0] out_flags_o
);

    localparam int MAN = `FMUL_MAN_BITS;
    localparam int MW  = MAN + 1;               // mantissa with hidden bit
    localparam int PW  = 2 * MW;                // product width
    localparam int LZW = $clog2(MW);
    localparam int EW  = `FMUL_EXP_BITS + 2;    // exponent sum with headroom
    localparam logic [EW-1:0]  BIAS    = EW'(`FMUL_BIAS);
    localparam logic [EW-1:0]  EXP_TOP = BIAS + EW'((1 << `FMUL_EXP_BITS) - 2);
    localparam logic [LZW-1:0] SHR_MAX = LZW'(27);

    logic zero_a, sub_a, inf_a, nan_a, snan_a;
    logic zero_b, sub_b, inf_b, nan_b, snan_b;
    logic ez_a, ez_b;                     // exponent field is zero
    logic sign_c;
    logic [EW-1:0]  exp_sum, exp_norm;
    logic [MW-1:0]  man_a, man_b, den_man, norm_a, norm_b;
    logic [LZW-1:0] lzc;
    logic                       spec_c;
    logic [`FMUL_WIDTH-1:0]     spec_res_c;
    logic [`FMUL_FLAG_BITS-1:0] spec_flags_c;

    fp_classifier u_cls_a (
        .operand_i (a_i),
        .is_zero_o (zero_a),
        .is_sub_o  (sub_a),
        .is_inf_o  (inf_a),
        .is_nan_o  (nan_a),
        .is_snan_o (snan_a)
    );

    fp_classifier u_cls_b (
        .operand_i (b_i),
        .is_zero_o (zero_b),
        .is_sub_o  (sub_b),
        .is_inf_o  (inf_b),
        .is_nan_o  (nan_b),
        .is_snan_o (snan_b)
    );

    // --------------------
    // operand prep
    // --------------------
    assign sign_c = a_i[`FMUL_WIDTH-1] ^ b_i[`FMUL_WIDTH-1];
    assign ez_a   = zero_a | sub_a;
    assign ez_b   = zero_b | sub_b;

    // a subnormal counts as exponent 1
    assign exp_sum = EW'(a_i[`FMUL_WIDTH-2:MAN] | {{(`FMUL_EXP_BITS-1){1'b0}}, ez_a})
                   + EW'(b_i[`FMUL_WIDTH-2:MAN] | {{(`FMUL_EXP_BITS-1){1'b0}}, ez_b});

    assign man_a   = {~ez_a, a_i[MAN-1:0]};
    assign man_b   = {~ez_b, b_i[MAN-1:0]};
    assign den_man = ez_a ? man_a : man_b;

    always_comb begin
        lzc = '0;
        for (int i = 0; i < MW; i++) begin
            if (den_man[i]) lzc = LZW'(MW - 1 - i);  // highest set bit wins
        end
    end

    // two subnormals never reach the datapath, they resolve as special
    assign norm_a = (ez_a & ~ez_b) ? man_a << lzc : man_a;
    assign norm_b = (ez_b & ~ez_a) ? man_b << lzc : man_b;
    assign exp_norm = ~(ez_a ^ ez_b)     ? exp_sum :
                      (exp_sum > EW'(lzc)) ? exp_sum - EW'(lzc) : '0;

    always_comb begin
        spec_c       = 1'b1;
        spec_res_c   = `FMUL_QNAN;
        spec_flags_c = '0;
        if ((inf_a & zero_b) | (zero_a & inf_b)) begin
            spec_flags_c[fmul_pkg::NV] = 1'b1;
        end else if (nan_a | nan_b) begin
            spec_flags_c[fmul_pkg::NV] = snan_a | snan_b;
        end else if (inf_a | inf_b) begin
            spec_res_c = {sign_c, {`FMUL_EXP_BITS{1'b1}}, {MAN{1'b0}}};
        end else if (zero_a | zero_b) begin
            spec_res_c = {sign_c, {(`FMUL_WIDTH-1){1'b0}}};
        end else if (sub_a & sub_b) begin
            spec_res_c = {sign_c, {(`FMUL_WIDTH-1){1'b0}}};  // far below the smallest subnormal
            spec_flags_c[fmul_pkg::UF] = 1'b1;
            spec_flags_c[fmul_pkg::NX] = 1'b1;
        end else begin
            spec_c = 1'b0;
        end
    end

    // --------------------
    // stage 1 and 2 regs
    // --------------------
    logic valid_s1, valid_s2;
    logic sign_s1, sign_s2, spec_s1, spec_s2, need_shr_s2;
    fmul_pkg::roundmode_e rm_s1, rm_s2;
    logic [EW-1:0]              exp_s1, exp_s2;
    logic [MW-1:0]              man_a_s1, man_b_s1;
    logic [LZW-1:0]             shr_s2;
    logic [`FMUL_WIDTH-1:0]     spec_res_s1, spec_res_s2;
    logic [`FMUL_FLAG_BITS-1:0] spec_flags_s1, spec_flags_s2;
    logic [PW-1:0]              prod;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_s1    <= 1'b0;
            valid_s2    <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            valid_s1    <= in_valid_i;
            valid_s2    <= valid_s1;
            out_valid_o <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        sign_s1       <= sign_c;
        rm_s1         <= rm_i;
        exp_s1        <= exp_norm;
        man_a_s1      <= norm_a;
        man_b_s1      <= norm_b;
        spec_s1       <= spec_c;
        spec_res_s1   <= spec_res_c;
        spec_flags_s1 <= spec_flags_c;

        sign_s2       <= sign_s1;
        rm_s2         <= rm_s1;
        exp_s2        <= exp_s1;
        spec_s2       <= spec_s1;
        spec_res_s2   <= spec_res_s1;
        spec_flags_s2 <= spec_flags_s1;
        need_shr_s2   <= exp_s1 <= BIAS;
        // right shift to reach the subnormal range, past 27 nothing changes
        shr_s2 <= (exp_s1 <= BIAS + EW'(1) - EW'(SHR_MAX)) ? SHR_MAX :
                  (exp_s1 <= BIAS)                          ? LZW'(BIAS + EW'(1) - exp_s1) :
                                                              '0;
    end

    mant_mul u_mul (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .a_i     (man_a_s1),
        .b_i     (man_b_s1),
        .prod_o  (prod)
    );

    // --------------------
    // stage 3
    // --------------------
    logic msb, lost, guard, sticky, rnd_carry, inexact, ovf, tiny;
    logic [EW-1:0]              shift_exp, round_exp, exp_unb;
    logic [LZW-1:0]             shr_amt;
    logic [PW-1:0]              shifted;
    logic [MAN-1:0]             rnd_mant;
    logic [`FMUL_WIDTH-1:0]     norm_result;
    logic [`FMUL_FLAG_BITS-1:0] norm_flags;

    assign msb       = prod[PW-1];
    assign shift_exp = exp_s2 + EW'(msb);
    assign shr_amt   = shr_s2 + LZW'(~need_shr_s2 & msb);  // normal range, msb at 47
    assign shifted   = prod >> shr_amt;
    assign lost      = |(prod & ((PW'(1) << shr_amt) - PW'(1)));
    assign guard     = shifted[MAN-1];
    assign sticky    = |shifted[MAN-2:0] | lost;

    fp_rounding u_round (
        .mant_i    (shifted[2*MAN-1:MAN]),
        .guard_i   (guard),
        .sticky_i  (sticky),
        .sign_i    (sign_s2),
        .rm_i      (rm_s2),
        .mant_o    (rnd_mant),
        .carry_o   (rnd_carry),
        .inexact_o (inexact)
    );

    assign round_exp = shift_exp + EW'(rnd_carry);
    assign exp_unb   = round_exp - BIAS;
    assign ovf       = round_exp > EXP_TOP;
    assign tiny      = round_exp <= BIAS;  // exponent field 0 after rounding

    always_comb begin
        norm_flags = '0;
        norm_flags[fmul_pkg::NX] = inexact | ovf;
        norm_flags[fmul_pkg::UF] = inexact & tiny;
        norm_flags[fmul_pkg::OF] = ovf;
        if (ovf) begin
            norm_result = {sign_s2, {`FMUL_EXP_BITS{1'b1}}, {MAN{1'b0}}};  // inf in any mode
        end else if (tiny) begin
            norm_result = {sign_s2, {`FMUL_EXP_BITS{1'b0}}, rnd_mant};
        end else begin
            norm_result = {sign_s2, exp_unb[`FMUL_EXP_BITS-1:0], rnd_mant};
        end
    end

    always_ff @(posedge clk) begin
        out_result_o <= spec_s2 ? spec_res_s2 : norm_result;
        out_flags_o  <= spec_s2 ? spec_flags_s2 : norm_flags;
    end

endmodule

/* src/fmul_csr.sv */
`include "fmul_defines.svh"

module fmul_csr (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       cfg_req_i,
    input  logic                       cfg_we_i,
    input  fmul_pkg::roundmode_e       cfg_rm_i,
    input  logic                       upd_i,
    input  logic [`FMUL_FLAG_BITS-1:0] upd_flags_i,
    output logic                       cfg_ack_o,
    output fmul_pkg::roundmode_e       rm_o,
    output logic [`FMUL_FLAG_BITS-1:0] flags_o
);

    logic wr_en;

    // only the rising half of the handshake writes
    assign wr_en = cfg_req_i & ~cfg_ack_o & cfg_we_i;

    // ack follows req one cycle late, both edges
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_ack_o <= 1'b0;
        end else begin
            cfg_ack_o <= cfg_req_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rm_o <= fmul_pkg::RNE;
        end else if (wr_en) begin
            rm_o <= cfg_rm_i;
        end
    end

    // sticky flags, a write clears them and beats a core update
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flags_o <= '0;
        end else if (wr_en) begin
            flags_o <= '0;
        end else if (upd_i) begin
            flags_o <= flags_o | upd_flags_i;
        end
    end

endmodule

/* src/fmul_defines.svh */
`ifndef FMUL_DEFINES_SVH
`define FMUL_DEFINES_SVH

// --------------------
// binary32 layout
// --------------------

// exponent field width
`define FMUL_EXP_BITS 8

// stored mantissa, hidden bit not counted
`define FMUL_MAN_BITS 23

// full operand width
`define FMUL_WIDTH 32

`define FMUL_BIAS 127

// canonical quiet nan, every nan result uses it
`define FMUL_QNAN 32'h7fc00000

// --------------------
// exception flags
// --------------------

// nx uf of dz nv, bit order in fmul_pkg::flag_e
`define FMUL_FLAG_BITS 5

`endif

/* src/fmul_pkg.sv */
package fmul_pkg;

    // rounding modes in frm encoding
    // codes 5 to 7 are not named and round like RNE
    typedef enum logic [2:0] {
        RNE = 3'd0,  // nearest, ties to even
        RTZ = 3'd1,  // toward zero
        RDN = 3'd2,  // toward -inf
        RUP = 3'd3,  // toward +inf
        RMM = 3'd4   // nearest, ties away from zero
    } roundmode_e;

    // bit positions inside the flag vector, same order as fflags
    typedef enum int unsigned {
        NX = 0,  // inexact
        UF = 1,  // underflow
        OF = 2,  // overflow
        DZ = 3,  // divide by zero, never set by a multiply
        NV = 4   // invalid
    } flag_e;

    // operation handshake controller
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } op_state_e;

endpackage

/* src/fmul_unit.sv */
`include "fmul_defines.svh"

module fmul_unit (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       op_req_i,
    input  logic [`FMUL_WIDTH-1:0]     op_a_i,
    input  logic [`FMUL_WIDTH-1:0]     op_b_i,
    input  logic                       cfg_req_i,
    input  logic                       cfg_we_i,
    input  fmul_pkg::roundmode_e       cfg_rm_i,
    output logic                       op_ack_o,
    output logic [`FMUL_WIDTH-1:0]     result_o,
    output logic [`FMUL_FLAG_BITS-1:0] exc_o,
    output logic                       cfg_ack_o,
    output fmul_pkg::roundmode_e       rm_o,
    output logic [`FMUL_FLAG_BITS-1:0] flags_o
);

    fmul_pkg::op_state_e        state_q;
    logic                       issue_q;
    logic                       core_valid;
    logic [`FMUL_WIDTH-1:0]     core_result;
    logic [`FMUL_FLAG_BITS-1:0] core_flags;

    // --------------------
    // op handshake
    // --------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= fmul_pkg::IDLE;
            issue_q  <= 1'b0;
            op_ack_o <= 1'b0;
            result_o <= '0;
            exc_o    <= '0;
        end else begin
            issue_q <= 1'b0;  // single cycle pulse
            case (state_q)
                fmul_pkg::IDLE: begin
                    if (op_req_i) begin
                        issue_q <= 1'b1;
                        state_q <= fmul_pkg::BUSY;
                    end
                end
                fmul_pkg::BUSY: begin
                    if (core_valid) begin
                        result_o <= core_result;
                        exc_o    <= core_flags;
                        op_ack_o <= 1'b1;
                        state_q  <= fmul_pkg::DONE;
                    end
                end
                fmul_pkg::DONE: begin
                    if (!op_req_i) begin  // wait for req to drop before releasing ack
                        op_ack_o <= 1'b0;
                        state_q  <= fmul_pkg::IDLE;
                    end
                end
                default: state_q <= fmul_pkg::IDLE;
            endcase
        end
    end

    fmul_core u_core (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (issue_q),
        .a_i          (op_a_i),
        .b_i          (op_b_i),
        .rm_i         (rm_o),
        .out_valid_o  (core_valid),
        .out_result_o (core_result),
        .out_flags_o  (core_flags)
    );

    fmul_csr u_csr (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_req_i   (cfg_req_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_rm_i    (cfg_rm_i),
        .upd_i       (core_valid),
        .upd_flags_i (core_flags),
        .cfg_ack_o   (cfg_ack_o),
        .rm_o        (rm_o),
        .flags_o     (flags_o)
    );

endmodule

/* src/fp_classifier.sv */
`include "fmul_defines.svh"

module fp_classifier (
    input  logic [`FMUL_WIDTH-1:0] operand_i,
    output logic                   is_zero_o,
    output logic                   is_sub_o,
    output logic                   is_inf_o,
    output logic                   is_nan_o,
    output logic                   is_snan_o
);

    logic [`FMUL_EXP_BITS-1:0] exp_f;
    logic [`FMUL_MAN_BITS-1:0] man_f;
    logic                      exp_zero;
    logic                      exp_ones;
    logic                      man_zero;

    assign exp_f = operand_i[`FMUL_WIDTH-2 -: `FMUL_EXP_BITS];
    assign man_f = operand_i[`FMUL_MAN_BITS-1:0];

    assign exp_zero = ~|exp_f;
    assign exp_ones = &exp_f;
    assign man_zero = ~|man_f;

    assign is_zero_o = exp_zero & man_zero;
    assign is_sub_o  = exp_zero & ~man_zero;
    assign is_inf_o  = exp_ones & man_zero;
    assign is_nan_o  = exp_ones & ~man_zero;
    // quiet bit is the mantissa msb
    assign is_snan_o = is_nan_o & ~man_f[`FMUL_MAN_BITS-1];

endmodule

/* src/fp_rounding.sv */
`include "fmul_defines.svh"

module fp_rounding (
    input  logic [`FMUL_MAN_BITS-1:0] mant_i,
    input  logic                      guard_i,
    input  logic                      sticky_i,
    input  logic                      sign_i,
    input  fmul_pkg::roundmode_e      rm_i,
    output logic [`FMUL_MAN_BITS-1:0] mant_o,
    output logic                      carry_o,
    output logic                      inexact_o
);

    localparam int RW = `FMUL_MAN_BITS + 1;

    logic round_up;

    assign inexact_o = guard_i | sticky_i;

    always_comb begin
        case (rm_i)
            fmul_pkg::RTZ: round_up = 1'b0;
            fmul_pkg::RDN: round_up = inexact_o & sign_i;
            fmul_pkg::RUP: round_up = inexact_o & ~sign_i;
            fmul_pkg::RMM: round_up = guard_i;  // tie goes away from zero
            default: begin
                // RNE, also the reserved codes
                round_up = guard_i & (sticky_i | mant_i[0]);
            end
        endcase
    end

    // carry out means the mantissa wrapped to zero and the exponent steps up
    assign {carry_o, mant_o} = {1'b0, mant_i} + RW'(round_up);

endmodule

/* src/mant_mul.sv */
`include "fmul_defines.svh"

module mant_mul (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [`FMUL_MAN_BITS:0]    a_i,
    input  logic [`FMUL_MAN_BITS:0]    b_i,
    output logic [2*`FMUL_MAN_BITS+1:0] prod_o
);

    localparam int W   = `FMUL_MAN_BITS + 1;  // 24
    localparam int DIG = W / 2 + 1;           // 13 booth digits, unsigned b needs the extra one
    localparam int PPW = W + 2;               // room for 2a and the sign

    logic [W+2:0]   b_ext;
    logic [PPW-1:0] pp [DIG];
    logic [2*W-1:0] sum;

    assign b_ext = {2'b00, b_i, 1'b0};  // implicit b[-1] = 0

    // radix-4 digit select
    always_comb begin
        for (int i = 0; i < DIG; i++) begin
            case (b_ext[2*i +: 3])
                3'b001, 3'b010: pp[i] = {2'b00, a_i};         // +a
                3'b011:         pp[i] = {1'b0, a_i, 1'b0};    // +2a
                3'b100:         pp[i] = -{1'b0, a_i, 1'b0};   // -2a
                3'b101, 3'b110: pp[i] = -{2'b00, a_i};        // -a
                default:        pp[i] = '0;
            endcase
        end
    end

    // partial products are sign extended to full width before the sum
    always_comb begin
        sum = '0;
        for (int i = 0; i < DIG; i++) begin
            sum = sum + ({{(2*W-PPW){pp[i][PPW-1]}}, pp[i]} << (2 * i));
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod_o <= '0;
        end else begin
            prod_o <= sum;
        end
    end

endmodule

/* tests/tb_fmul_model.svh */
`ifndef TB_FMUL_MODEL_SVH
`define TB_FMUL_MODEL_SVH

localparam int WAIT_LIMIT = 40;  // negedges per handshake phase

// --------------------
// reference multiply
// --------------------

// normal operands with a normal result only, returns {nx, result}
function automatic logic [`FMUL_WIDTH:0] ref_mul(
    input logic [`FMUL_WIDTH-1:0] a,
    input logic [`FMUL_WIDTH-1:0] b,
    input fmul_pkg::roundmode_e   rm
);
    logic [47:0] prod;
    logic [22:0] mant;
    logic [9:0]  exp_r;
    logic        sign;
    logic        guard;
    logic        sticky;
    logic        up;
    prod  = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
    sign  = a[31] ^ b[31];
    exp_r = 10'(a[30:23]) + 10'(b[30:23]) - 10'(`FMUL_BIAS);
    if (prod[47]) begin
        exp_r  = exp_r + 10'd1;  // product in [2,4)
        mant   = prod[46:24];
        guard  = prod[23];
        sticky = |prod[22:0];
    end else begin
        mant   = prod[45:23];
        guard  = prod[22];
        sticky = |prod[21:0];
    end
    case (rm)
        fmul_pkg::RTZ: up = 1'b0;
        fmul_pkg::RDN: up = (guard | sticky) & sign;
        fmul_pkg::RUP: up = (guard | sticky) & ~sign;
        fmul_pkg::RMM: up = guard;
        default:       up = guard & (sticky | mant[0]);
    endcase
    if (up) begin
        if (&mant) begin
            exp_r = exp_r + 10'd1;  // mantissa wraps to 1.0
        end
        mant = mant + 23'd1;
    end
    return {guard | sticky, sign, exp_r[7:0], mant};
endfunction

// --------------------
// handshake drivers
// --------------------

task automatic wait_ack(input logic cfg, input logic level);
    int cycles;
    cycles = 0;
    while ((cfg ? cfg_ack_o : op_ack_o) !== level && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
    end
    if ((cfg ? cfg_ack_o : op_ack_o) !== level) begin
        stop_on_error($sformatf("%s stayed at %b past the wait limit in %s",
                                cfg ? "cfg_ack_o" : "op_ack_o", !level, test_name));
    end
endtask

// one full four-phase operation, req held for extra cycles after ack
task automatic run_op(
    input string                      name,
    input logic [`FMUL_WIDTH-1:0]     a,
    input logic [`FMUL_WIDTH-1:0]     b,
    input logic [`FMUL_WIDTH-1:0]     res,
    input logic [`FMUL_FLAG_BITS-1:0] flags,
    input int                         hold_cycles
);
    test_name  = name;
    exp_result = res;
    exp_exc    = flags;
    op_a_i     = a;
    op_b_i     = b;
    op_req_i   = 1'b1;
    wait_ack(1'b0, 1'b1);
    acc_flags = acc_flags | flags;
    repeat (hold_cycles) @(negedge clk);
    op_req_i = 1'b0;
    wait_ack(1'b0, 1'b0);
endtask

task automatic cfg_access(input logic we, input fmul_pkg::roundmode_e rm);
    test_name = we ? "cfg_write" : "cfg_read";
    cfg_we_i  = we;
    cfg_rm_i  = rm;
    cfg_req_i = 1'b1;
    wait_ack(1'b1, 1'b1);
    if (we) begin
        acc_flags = '0;  // write clears the sticky flags
        cur_rm    = rm;
    end
    cfg_req_i = 1'b0;
    cfg_we_i  = 1'b0;
    wait_ack(1'b1, 1'b0);
endtask

`endif

/* tests/tb_fmul_unit.sv */
`include "fmul_defines.svh"

module tb_fmul_unit;

    logic                       clk;
    logic                       rst_n_i;
    logic                       op_req_i;
    logic [`FMUL_WIDTH-1:0]     op_a_i;
    logic [`FMUL_WIDTH-1:0]     op_b_i;
    logic                       cfg_req_i;
    logic                       cfg_we_i;
    fmul_pkg::roundmode_e       cfg_rm_i;
    logic                       op_ack_o;
    logic [`FMUL_WIDTH-1:0]     result_o;
    logic [`FMUL_FLAG_BITS-1:0] exc_o;
    logic                       cfg_ack_o;
    fmul_pkg::roundmode_e       rm_o;
    logic [`FMUL_FLAG_BITS-1:0] flags_o;

    // expected state of the running operation
    string                      test_name;
    logic [`FMUL_WIDTH-1:0]     exp_result;
    logic [`FMUL_FLAG_BITS-1:0] exp_exc;
    logic [`FMUL_FLAG_BITS-1:0] acc_flags;  // or of exc since the last write
    fmul_pkg::roundmode_e       cur_rm;

    fmul_unit u_dut (.*);

    initial begin
        clk = 1'b1;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    `include "tb_fmul_model.svh"

    // --------------------
    // checks
    // --------------------
    reset_state: assert property (@(posedge clk) !rst_n_i |->
        !op_ack_o && !cfg_ack_o && result_o == '0 && exc_o == '0 && flags_o == '0
        && rm_o == fmul_pkg::RNE)
        else stop_on_error("outputs not at their reset values while reset is held");

    ack_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(op_ack_o) |-> $past(op_req_i) && $past(op_req_i, 5) && !$past(op_req_i, 6))
        else stop_on_error($sformatf("op_ack_o rose without req 4 edges before in %s",
                                     test_name));

    ack_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (op_ack_o && op_req_i) |=> op_ack_o)
        else stop_on_error("op_ack_o dropped while op_req_i was still high");

    ack_release: assert property (@(posedge clk) disable iff (!rst_n_i)
        (op_ack_o && !op_req_i) |=> !op_ack_o)
        else stop_on_error("op_ack_o stayed high a cycle after op_req_i fell");

    result_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (op_ack_o && $past(op_ack_o)) |-> $stable(result_o) && $stable(exc_o))
        else stop_on_error($sformatf("result changed while req was held in %s", test_name));

    result_value: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(op_ack_o) |-> result_o == exp_result)
        else stop_on_error($sformatf("Error %s: expected result %h, actual %h",
                                     test_name, exp_result, result_o));

    exc_value: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(op_ack_o) |-> exc_o == exp_exc)
        else stop_on_error($sformatf("Error %s: expected exc %b, actual %b",
                                     test_name, exp_exc, exc_o));

    flags_value: assert property (@(posedge clk) disable iff (!rst_n_i)
        flags_o == acc_flags)
        else stop_on_error($sformatf("Error %s: expected flags %b, actual %b",
                                     test_name, acc_flags, flags_o));

    rm_value: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(cfg_ack_o) |-> rm_o == cur_rm)
        else stop_on_error($sformatf("Error %s: expected rm %0d, actual %0d",
                                     test_name, cur_rm, rm_o));

    // --------------------
    // stimulus
    // --------------------
    initial begin
        logic [`FMUL_WIDTH-1:0] a;
        logic [`FMUL_WIDTH-1:0] b;
        logic [`FMUL_WIDTH:0]   model;
        void'($urandom(33264));
        rst_n_i    = 1'b1;
        op_req_i   = 1'b0;
        op_a_i     = '0;
        op_b_i     = '0;
        cfg_req_i  = 1'b0;
        cfg_we_i   = 1'b0;
        cfg_rm_i   = fmul_pkg::RNE;
        test_name  = "reset";
        exp_result = '0;
        exp_exc    = '0;
        acc_flags  = '0;
        cur_rm     = fmul_pkg::RNE;
        @(negedge clk);
        rst_n_i = 1'b0;
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        run_op("first_op", 32'h3fc00000, 32'h40000000, 32'h40400000, 5'b00000, 0);

        // new rounding mode and cleared flags while req is held, a reissue would show up
        fork
            run_op("held_req", 32'h3f800001, 32'h3f800001, 32'h3f800002, 5'b00001, 6);
            begin
                wait_ack(1'b0, 1'b1);
                cfg_access(1'b1, fmul_pkg::RUP);
                test_name = "held_req";
            end
        join

        // exponents 90..159 keep every product normal
        for (int i = 0; i < 200; i++) begin
            if (i % 40 == 0) begin
                cfg_access(1'b1, fmul_pkg::roundmode_e'(3'(i / 40)));
            end
            a = {1'($urandom), 8'(90 + $urandom % 70), 23'($urandom)};
            b = {1'($urandom), 8'(90 + $urandom % 70), 23'($urandom)};
            model = ref_mul(a, b, cur_rm);
            run_op($sformatf("normal_%0d_rm%0d", i, cur_rm), a, b, model[31:0],
                   {4'b0000, model[32]}, 0);
        end

        cfg_access(1'b1, fmul_pkg::RNE);
        for (int i = 0; i < 10; i++) begin
            a = {1'($urandom), 8'hff, 1'b1, 22'($urandom)};  // quiet nan
            b = {1'($urandom), 8'(1 + $urandom % 254), 23'($urandom)};
            run_op("qnan_random", a, b, `FMUL_QNAN, 5'b00000, 0);
        end
        run_op("snan_a", 32'h7f800001, 32'h40000000, `FMUL_QNAN, 5'b10000, 0);
        run_op("snan_b", 32'h3f800000, 32'hffa00000, `FMUL_QNAN, 5'b10000, 0);
        run_op("qnan_x_inf", 32'hffc00000, 32'h7f800000, `FMUL_QNAN, 5'b00000, 0);
        run_op("qnan_x_snan", 32'h7fc00000, 32'h7f800001, `FMUL_QNAN, 5'b10000, 0);
        run_op("qnan_x_zero", 32'h7fc00000, 32'h00000000, `FMUL_QNAN, 5'b00000, 0);
        run_op("inf_x_zero", 32'h7f800000, 32'h80000000, `FMUL_QNAN, 5'b10000, 0);
        run_op("zero_x_inf", 32'h00000000, 32'hff800000, `FMUL_QNAN, 5'b10000, 0);
        run_op("inf_x_fin", 32'hff800000, 32'h40400000, 32'hff800000, 5'b00000, 0);
        run_op("inf_x_sub", 32'h7f800000, 32'h80000010, 32'hff800000, 5'b00000, 0);
        run_op("fin_x_inf", 32'hc0000000, 32'hff800000, 32'h7f800000, 5'b00000, 0);
        run_op("zero_x_fin", 32'h80000000, 32'h3f800000, 32'h80000000, 5'b00000, 0);
        run_op("zero_x_sub", 32'h00000000, 32'h80000005, 32'h80000000, 5'b00000, 0);
        run_op("fin_x_zero", 32'h42000000, 32'h00000000, 32'h00000000, 5'b00000, 0);
        run_op("sub_x_sub", 32'h00012345, 32'h80400000, 32'h80000000, 5'b00011, 0);
        run_op("sub_x_sub_min", 32'h807fffff, 32'h00000001, 32'h80000000, 5'b00011, 0);

        // overflow is infinity in every mode
        for (int m = 0; m < 5; m++) begin
            cfg_access(1'b1, fmul_pkg::roundmode_e'(3'(m)));
            run_op("overflow", 32'h7f000000, 32'h40000000, 32'h7f800000, 5'b00101, 0);
            run_op("overflow_neg", 32'hff7fffff, 32'h7f7fffff, 32'hff800000, 5'b00101, 0);
        end

        // sticky flags build up, survive a read and clear on a write
        cfg_access(1'b1, fmul_pkg::RUP);
        model = ref_mul(32'h3f800001, 32'h3f800001, cur_rm);
        run_op("flag_nx", 32'h3f800001, 32'h3f800001, model[31:0], {4'b0000, model[32]}, 0);
        run_op("flag_nv", 32'h7f800001, 32'h3f800000, `FMUL_QNAN, 5'b10000, 0);
        run_op("flag_of", 32'h7f000000, 32'h7f000000, 32'h7f800000, 5'b00101, 0);
        run_op("flag_uf", 32'h00000003, 32'h80000001, 32'h80000000, 5'b00011, 0);
        cfg_access(1'b0, fmul_pkg::RDN);
        cfg_access(1'b1, fmul_pkg::RMM);
        run_op("after_clear", 32'h3fc00000, 32'h40000000, 32'h40400000, 5'b00000, 0);

        repeat (4) @(negedge clk);
        $display("sim passed");
        $finish;
    end

endmodule
